//--- verilog/hififo_pkg.sv
`default_nettype none

package hififo_pkg;

   // channel count, one per direction
   localparam int num_channels = 2;
   localparam int chan_width = $clog2(num_channels);

   // read request address and host command word widths
   localparam int addr_width = 64;
   localparam int data_width = 64;

   // address bits below the high part
   localparam int count_bits = 22;
   // descriptor size as a power of two
   localparam int block_shift = 3;
   // pointers count descriptors, not bytes
   localparam int ptr_width = count_bits - block_shift;
   // address bits held by the addr_high command
   localparam int high_width = addr_width - count_bits;

   // per channel status word
   localparam int status_width = 32;

   // command word fields
   localparam int opcode_bits = 3;
   localparam int abort_bit = 8;

   typedef logic [chan_width-1:0] chan_t;

   // opcode sits in the low bits of every command word
   typedef enum logic [opcode_bits-1:0]
   {
      cmd_nop = 3'd0,
      cmd_interrupt = 3'd1,
      cmd_stop = 3'd2,
      cmd_addr_high = 3'd3,
      cmd_abort = 3'd4
   } cmd_opcode_t;

   // host command strobe, consumed in its cycle
   typedef struct packed
   {
      logic valid;
      chan_t channel;
      logic [data_width-1:0] data;
   } host_write_t;

   // descriptor read request, no back-pressure
   typedef struct packed
   {
      logic valid;
      chan_t channel;
      logic [addr_width-1:0] addr;
   } read_request_t;

   // one status word per channel
   typedef logic [num_channels-1:0][status_width-1:0] status_t;

endpackage

`default_nettype wire

//--- verilog/hififo_fetch_descriptor.sv
`timescale 1ns/100ps
`default_nettype none

module hififo_fetch_descriptor
#(
   parameter hififo_pkg::chan_t channel = '0
)
(
   input wire logic clock,
   input wire logic rst,
   input wire hififo_pkg::host_write_t host_write,
   input wire logic request_ack,
   output logic request_valid,
   output logic [hififo_pkg::addr_width-1:0] request_addr,
   output logic [hififo_pkg::status_width-1:0] status,
   output logic interrupt
);

   hififo_pkg::cmd_opcode_t opcode;
   logic hit;
   logic write_interrupt;
   logic write_stop;
   logic write_addr_high;
   logic write_abort;
   logic [hififo_pkg::ptr_width-1:0] cmd_ptr;

   logic abort;
   logic reset_or_abort;
   logic [hififo_pkg::high_width-1:0] addr_high;
   logic [hififo_pkg::ptr_width-1:0] p_current;
   logic [hififo_pkg::ptr_width-1:0] p_stop;
   logic [hififo_pkg::ptr_width-1:0] p_interrupt;

   logic at_interrupt;
   logic at_interrupt_d;

   // only words addressed to this channel
   assign hit = host_write.valid && (host_write.channel == channel);
   assign opcode = hififo_pkg::cmd_opcode_t'(host_write.data[hififo_pkg::opcode_bits-1:0]);
   // pointer field, already in descriptor units
   assign cmd_ptr = host_write.data[hififo_pkg::count_bits-1:hififo_pkg::block_shift];

   // opcode decode
   assign write_interrupt = hit && (opcode == hififo_pkg::cmd_interrupt);
   assign write_stop = hit && (opcode == hififo_pkg::cmd_stop);
   assign write_addr_high = hit && (opcode == hififo_pkg::cmd_addr_high);
   assign write_abort = hit && (opcode == hififo_pkg::cmd_abort);

   // channel configuration
   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         // channel comes up aborted
         abort <= 1'b1;
         addr_high <= '0;
         p_interrupt <= '0;
      end
      else
      begin
         if (write_abort)
            abort <= host_write.data[hififo_pkg::abort_bit];
         if (write_addr_high)
            addr_high <= host_write.data[hififo_pkg::addr_width-1:hififo_pkg::count_bits];
         if (write_interrupt)
            p_interrupt <= cmd_ptr;
      end
   end

   // clear lags reset or abort by one cycle
   always_ff @(posedge clock)
   begin
      reset_or_abort <= rst | abort;
   end

   // pointer walk
   always_ff @(posedge clock)
   begin
      if (reset_or_abort)
      begin
         p_stop <= '0;
         p_current <= '0;
      end
      else
      begin
         if (write_stop)
            p_stop <= cmd_ptr;
         // one step per granted read
         if (request_ack)
            p_current <= p_current + 1;
      end
   end

   // ack cycle masks the request, so no double grant
   assign request_valid = (p_current != p_stop) && !request_ack;

   // high bits, descriptor index, zero byte offset
   assign request_addr = {addr_high, p_current, {hififo_pkg::block_shift{1'b0}}};

   // current pointer back in bytes
   assign status = {{(hififo_pkg::status_width - hififo_pkg::count_bits){1'b0}},
                    p_current, {hififo_pkg::block_shift{1'b0}}};

   assign at_interrupt = (p_current == p_interrupt);

   // rising edge of the match gives a one cycle pulse
   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         // set so the match right after reset is not an edge
         at_interrupt_d <= 1'b1;
         interrupt <= 1'b0;
      end
      else
      begin
         at_interrupt_d <= at_interrupt;
         interrupt <= at_interrupt && !at_interrupt_d;
      end
   end

endmodule

`default_nettype wire

//--- verilog/hififo_request_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module hififo_request_arbiter
(
   input wire logic clock,
   input wire logic rst,
   input wire logic [hififo_pkg::num_channels-1:0] request_valid,
   input wire logic [hififo_pkg::num_channels-1:0][hififo_pkg::addr_width-1:0] request_addr,
   output logic [hififo_pkg::num_channels-1:0] request_ack,
   output hififo_pkg::read_request_t read_request
);

   hififo_pkg::chan_t last_grant;
   hififo_pkg::chan_t grant;
   logic any_request;
   logic [hififo_pkg::num_channels-1:0] ack_next;

   assign any_request = |request_valid;

   // round robin search starting after the last winner
   always_comb
   begin
      int idx;
      grant = last_grant;
      // walk from farthest to nearest so the nearest requester wins
      for (int i = hififo_pkg::num_channels; i >= 1; i--)
      begin
         idx = (int'(last_grant) + i) % hififo_pkg::num_channels;
         if (request_valid[idx])
            grant = hififo_pkg::chan_t'(idx);
      end
   end

   // one hot ack for the winner
   always_comb
   begin
      ack_next = '0;
      if (any_request)
         ack_next[grant] = 1'b1;
   end

   // ack and strobe registered together so they line up
   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         request_ack <= '0;
         read_request.valid <= 1'b0;
         last_grant <= '0;
      end
      else
      begin
         request_ack <= ack_next;
         read_request.valid <= any_request;
         // address as the channel showed it in the request cycle
         read_request.channel <= grant;
         read_request.addr <= request_addr[grant];
         // remember the winner only on a real grant
         if (any_request)
            last_grant <= grant;
      end
   end

endmodule

`default_nettype wire

//--- verilog/hififo_dma_frontend.sv
`timescale 1ns/100ps
`default_nettype none

module hififo_dma_frontend
(
   input wire logic clock,
   input wire logic rst,
   input wire hififo_pkg::host_write_t host_write,
   output wire hififo_pkg::read_request_t read_request,
   output wire hififo_pkg::status_t status,
   output wire [hififo_pkg::num_channels-1:0] interrupt
);

   // channel to arbiter handshake
   wire [hififo_pkg::num_channels-1:0] request_valid;
   wire [hififo_pkg::num_channels-1:0] request_ack;
   wire [hififo_pkg::num_channels-1:0][hififo_pkg::addr_width-1:0] request_addr;

   // one fetch block per channel, all see the same host writes
   for (genvar ch = 0; ch < hififo_pkg::num_channels; ch++)
   begin : g_channel
      hififo_fetch_descriptor
      #(
         .channel(hififo_pkg::chan_t'(ch))
      )
      fetch_i
      (
         .clock(clock),
         .rst(rst),
         .host_write(host_write),
         .request_ack(request_ack[ch]),
         .request_valid(request_valid[ch]),
         .request_addr(request_addr[ch]),
         .status(status[ch]),
         .interrupt(interrupt[ch])
      );
   end

   // shared read request port
   hififo_request_arbiter arbiter_i
   (
      .clock(clock),
      .rst(rst),
      .request_valid(request_valid),
      .request_addr(request_addr),
      .request_ack(request_ack),
      .read_request(read_request)
   );

endmodule

`default_nettype wire

//--- testbench/hififo_checker.sv
`timescale 1ns/100ps
`default_nettype none

module hififo_checker
(
   input wire logic clock,
   input wire logic rst,
   input wire hififo_pkg::host_write_t host_write,
   input wire hififo_pkg::read_request_t read_request,
   input wire hififo_pkg::status_t status,
   input wire logic [hififo_pkg::num_channels-1:0] interrupt,
   input wire logic expect_valid,
   input wire hififo_pkg::chan_t expect_channel,
   input wire logic [31:0] expect_requests,
   input wire logic [31:0] expect_interrupts,
   output logic [hififo_pkg::num_channels-1:0][31:0] request_total,
   output int error_count
);

   typedef logic [hififo_pkg::ptr_width-1:0] ptr_t;

   // mirrored channel state, one entry per channel
   logic abort_m [hififo_pkg::num_channels];
   logic clear_m [hififo_pkg::num_channels];
   logic [hififo_pkg::high_width-1:0] high_m [hififo_pkg::num_channels];
   ptr_t ptr_m [hififo_pkg::num_channels];
   ptr_t stop_m [hififo_pkg::num_channels];
   ptr_t irq_ptr_m [hififo_pkg::num_channels];
   logic match_d_m [hififo_pkg::num_channels];
   logic irq_m [hififo_pkg::num_channels];
   logic [31:0] irq_total [hififo_pkg::num_channels];

   // what each channel offered in the previous cycle
   logic [hififo_pkg::addr_width-1:0] shown_addr [hififo_pkg::num_channels];
   logic shown_busy [hififo_pkg::num_channels];

   // last strobe, for the back to back check
   logic last_valid;
   hififo_pkg::chan_t last_chan;

   always @(posedge clock)
   begin
      int new_errors;
      logic hit;
      logic strobe;
      logic [hififo_pkg::opcode_bits-1:0] opcode;
      ptr_t cmd_ptr;
      logic [hififo_pkg::status_width-1:0] want_status;
      new_errors = 0;
      opcode = host_write.data[hififo_pkg::opcode_bits-1:0];
      cmd_ptr = host_write.data[hififo_pkg::count_bits-1:hififo_pkg::block_shift];
      for (int ch = 0; ch < hififo_pkg::num_channels; ch++)
      begin
         hit = host_write.valid && (host_write.channel == hififo_pkg::chan_t'(ch));
         strobe = read_request.valid && (read_request.channel == hififo_pkg::chan_t'(ch));
         // status is the pointer back in bytes
         want_status = '0;
         want_status[hififo_pkg::count_bits-1:0] = {ptr_m[ch], {hififo_pkg::block_shift{1'b0}}};
         if (!rst)
         begin
            if (status[ch] != want_status)
            begin
               $display("Fail at %0t ns: status[%0d] expected %h, got %h",
                        $time, ch, want_status, status[ch]);
               new_errors++;
            end
            if (interrupt[ch] != irq_m[ch])
            begin
               $display("Fail at %0t ns: interrupt[%0d] expected %b, got %b",
                        $time, ch, irq_m[ch], interrupt[ch]);
               new_errors++;
            end
            if (strobe && !shown_busy[ch])
            begin
               $display("Read request from idle channel %0d at %0t ns", ch, $time);
               new_errors++;
            end
            if (strobe && (read_request.addr != shown_addr[ch]))
            begin
               $display("Fail at %0t ns: read_request.addr ch%0d expected %h, got %h",
                        $time, ch, shown_addr[ch], read_request.addr);
               new_errors++;
            end
         end
         // totals seen on the ports
         if (rst)
         begin
            request_total[ch] <= '0;
            irq_total[ch] <= '0;
         end
         else
         begin
            if (strobe)
               request_total[ch] <= request_total[ch] + 32'd1;
            if (interrupt[ch])
               irq_total[ch] <= irq_total[ch] + 32'd1;
         end
         // command decode
         if (rst)
         begin
            abort_m[ch] <= 1'b1;
            high_m[ch] <= '0;
            irq_ptr_m[ch] <= '0;
         end
         else if (hit)
         begin
            case (hififo_pkg::cmd_opcode_t'(opcode))
               hififo_pkg::cmd_abort: abort_m[ch] <= host_write.data[hififo_pkg::abort_bit];
               hififo_pkg::cmd_addr_high:
                  high_m[ch] <= host_write.data[hififo_pkg::addr_width-1:hififo_pkg::count_bits];
               hififo_pkg::cmd_interrupt: irq_ptr_m[ch] <= cmd_ptr;
               default: ;
            endcase
         end
         // pointers clear a cycle after reset or abort
         clear_m[ch] <= rst | abort_m[ch];
         if (clear_m[ch])
         begin
            ptr_m[ch] <= '0;
            stop_m[ch] <= '0;
         end
         else
         begin
            if (hit && (hififo_pkg::cmd_opcode_t'(opcode) == hififo_pkg::cmd_stop))
               stop_m[ch] <= cmd_ptr;
            if (strobe)
               ptr_m[ch] <= ptr_m[ch] + ptr_t'(1);
         end
         shown_addr[ch] <= {high_m[ch], ptr_m[ch], {hififo_pkg::block_shift{1'b0}}};
         shown_busy[ch] <= (ptr_m[ch] != stop_m[ch]);
         // pulse on the first cycle of a pointer match
         if (rst)
         begin
            match_d_m[ch] <= 1'b1;
            irq_m[ch] <= 1'b0;
         end
         else
         begin
            match_d_m[ch] <= (ptr_m[ch] == irq_ptr_m[ch]);
            irq_m[ch] <= (ptr_m[ch] == irq_ptr_m[ch]) && !match_d_m[ch];
         end
      end
      if (!rst)
      begin
         // a busy channel never wins two cycles running
         if (read_request.valid && last_valid && (read_request.channel == last_chan))
         begin
            $display("Channel %0d was granted on two cycles in a row at %0t ns",
                     read_request.channel, $time);
            new_errors++;
         end
         if (expect_valid && (request_total[expect_channel] != expect_requests))
         begin
            $display("Fail at %0t ns: request total ch%0d expected %0d, got %0d",
                     $time, expect_channel, expect_requests, request_total[expect_channel]);
            new_errors++;
         end
         if (expect_valid && (irq_total[expect_channel] != expect_interrupts))
         begin
            $display("Fail at %0t ns: interrupt total ch%0d expected %0d, got %0d",
                     $time, expect_channel, expect_interrupts, irq_total[expect_channel]);
            new_errors++;
         end
      end
      last_valid <= read_request.valid && !rst;
      last_chan <= read_request.channel;
      if (rst)
         error_count <= 0;
      else
         error_count <= error_count + new_errors;
   end

endmodule

`default_nettype wire

//--- testbench/hififo_tb.sv
`timescale 1ns/100ps
`default_nettype none

module hififo_tb;

   // record kinds in the stim file
   localparam int kind_end = 0;
   localparam int kind_write = 1;
   localparam int kind_relaxed = 2;
   localparam int kind_wait = 3;
   localparam int kind_expect = 4;
   localparam int stim_depth = 256;

   logic clock;
   logic rst;
   hififo_pkg::host_write_t host_write;
   hififo_pkg::read_request_t read_request;
   hififo_pkg::status_t status;
   logic [hififo_pkg::num_channels-1:0] interrupt;

   // expectation port into the checker
   logic expect_valid;
   hififo_pkg::chan_t expect_channel;
   logic [31:0] expect_requests;
   logic [31:0] expect_interrupts;
   logic [hififo_pkg::num_channels-1:0][31:0] request_total;
   int checker_errors;
   int tb_errors;

   // four words per record
   logic [63:0] stim_mem [0:stim_depth-1];
   int cycle_count = 0;
   int cycle_limit = 1000000;

   hififo_dma_frontend UUT
   (
      .clock(clock),
      .rst(rst),
      .host_write(host_write),
      .read_request(read_request),
      .status(status),
      .interrupt(interrupt)
   );

   hififo_checker checker_i
   (
      .clock(clock),
      .rst(rst),
      .host_write(host_write),
      .read_request(read_request),
      .status(status),
      .interrupt(interrupt),
      .expect_valid(expect_valid),
      .expect_channel(expect_channel),
      .expect_requests(expect_requests),
      .expect_interrupts(expect_interrupts),
      .request_total(request_total),
      .error_count(checker_errors)
   );

   initial clock = 1'b0;

   // 100 ns period
   always #50 clock = ~clock;

   always @(posedge clock)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit)
      begin
         $display("Timeout after %0d cycles, the stimulus did not finish", cycle_count);
         $display("Test failed");
         $finish;
      end
   end

   // command word from opcode and field value
   function automatic logic [63:0] build_command(input logic [2:0] opcode,
                                                 input logic [63:0] value);
      logic [63:0] field;
      case (hififo_pkg::cmd_opcode_t'(opcode))
         hififo_pkg::cmd_interrupt, hififo_pkg::cmd_stop: field = value << hififo_pkg::block_shift;
         hififo_pkg::cmd_addr_high: field = value << hififo_pkg::count_bits;
         hififo_pkg::cmd_abort: field = value << hififo_pkg::abort_bit;
         default: field = value;
      endcase
      return field | {61'd0, opcode};
   endfunction

   // one strobe cycle, then idle
   task automatic drive_write(input hififo_pkg::chan_t chan, input logic [2:0] opcode,
                              input logic [63:0] value);
      hififo_pkg::host_write_t word;
      word.valid = 1'b1;
      word.channel = chan;
      word.data = build_command(opcode, value);
      @(posedge clock);
      host_write <= word;
      @(posedge clock);
      host_write <= '0;
   endtask

   task automatic request_totals_check(input hififo_pkg::chan_t chan,
                                       input logic [31:0] requests, input logic [31:0] irqs);
      int settle;
      settle = 0;
      // let strobes still in flight land
      while ((request_total[chan] < requests) && (settle < 16))
      begin
         @(posedge clock);
         settle++;
      end
      @(posedge clock);
      expect_valid <= 1'b1;
      expect_channel <= chan;
      expect_requests <= requests;
      expect_interrupts <= irqs;
      @(posedge clock);
      expect_valid <= 1'b0;
   endtask

   initial
   begin
      int rec;
      int n_records;
      int wait_total;
      int kind;
      int base;
      int gap;
      hififo_pkg::chan_t chan;
      logic [63:0] arg;
      logic [63:0] value;
      rst = 1'b1;
      host_write = '0;
      expect_valid = 1'b0;
      expect_channel = '0;
      expect_requests = '0;
      expect_interrupts = '0;
      tb_errors = 0;
      void'($urandom(32'hd0a053b9));
      $readmemh("testbench/hififo_stim.txt", stim_mem);
      // count records and waits for the run limit
      n_records = 0;
      wait_total = 0;
      while ((n_records < stim_depth / 4) && (int'(stim_mem[4 * n_records]) != kind_end))
      begin
         if (int'(stim_mem[4 * n_records]) == kind_wait)
            wait_total += int'(stim_mem[4 * n_records + 2]);
         n_records++;
      end
      if (n_records == 0)
      begin
         $display("No stimulus records were read from testbench/hififo_stim.txt");
         tb_errors++;
      end
      cycle_limit = 8 + wait_total + 20 * n_records + 100;
      repeat (8) @(posedge clock);
      rst <= 1'b0;
      for (rec = 0; rec < n_records; rec++)
      begin
         base = 4 * rec;
         kind = int'(stim_mem[base]);
         chan = hififo_pkg::chan_t'(stim_mem[base + 1]);
         arg = stim_mem[base + 2];
         value = stim_mem[base + 3];
         case (kind)
            kind_write: drive_write(chan, arg[2:0], value);
            kind_relaxed:
            begin
               // idle gap of 0 to 3 cycles
               gap = int'($urandom % 4);
               repeat (gap) @(posedge clock);
               drive_write(chan, arg[2:0], value);
            end
            kind_wait: repeat (int'(arg)) @(posedge clock);
            kind_expect: request_totals_check(chan, arg[31:0], value[31:0]);
            default:
            begin
               $display("Record %0d has unknown kind %0d", rec, kind);
               tb_errors++;
            end
         endcase
      end
      repeat (2) @(posedge clock);
      $display("Errors: checker %0d, testbench %0d", checker_errors, tb_errors);
      if ((checker_errors == 0) && (tb_errors == 0))
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/hififo_stim.txt
// kind chan arg value, all hex
// kind 1 write, 2 write after random gap, 3 wait arg cycles, 4 expect arg requests value irqs
// write arg is the opcode: 1 interrupt ptr, 2 stop ptr, 3 high address, 4 abort level
// idle after reset, stop writes are ignored
1 0 2 5
1 1 2 3
3 0 a 0
4 0 0 0
4 1 0 0
// channel 0 walk of 6 with interrupt at 3
2 0 4 0
2 0 3 2a5
2 0 1 3
1 0 2 6
3 0 e 0
4 0 6 1
// both channels busy
2 1 4 0
2 1 3 13
2 1 1 2
1 0 2 10
1 1 2 8
3 0 1e 0
4 0 10 1
4 1 8 1
// abort during a long walk, seven strobes get out
1 0 2 64
3 0 a 0
1 0 4 1
3 0 5 0
4 0 17 1
// restart from pointer 0
2 0 4 0
2 0 2 5
3 0 f 0
4 0 1c 2
4 1 8 1
0 0 0 0

//--- list.f
verilog/hififo_pkg.sv
verilog/hififo_fetch_descriptor.sv
verilog/hififo_request_arbiter.sv
verilog/hififo_dma_frontend.sv
testbench/hififo_checker.sv
testbench/hififo_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the hififo testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module hififo_tb -o hififo_sim
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit 1
fi

sim_out=$(./obj_dir/hififo_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test completed successfully"; then
   exit 0
fi
exit 1
